//--- rtl/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    localparam int xlen = 32;
    localparam int regAddrWidth = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010; // LW and SW
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Sub    = 7'b0100000;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5
    } aluOp_t;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFields;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFields;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sFields;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } bFields;
    } instr_t;

    typedef struct packed {
        logic   regWrite;
        logic   aluSrcImm;
        logic   memWrite;
        logic   memToReg;
        logic   branch;
        logic   branchOnNotEqual;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            regWrite;
        logic [4:0]      rd;
        logic [xlen-1:0] regData;
        logic            memWrite;
        logic [xlen-1:0] memAddr;
    } retire_t;

    typedef struct packed {
        logic        enable;
        logic [7:0]  wordAddr;
        logic [31:0] data;
    } progWrite_t;

endpackage

`default_nettype wire

//--- rtl/fetchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module fetchUnit import rvCorePkg::*; (
    input  logic            CLK,
    input  logic            reset,
    input  logic            branch,
    input  logic            branchOnNotEqual,
    input  logic            zero,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic            takeBranch;
    logic [xlen-1:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + imm; // Offset comes in already doubled

    // BNE inverts the sense of the zero flag
    assign takeBranch = branch & (zero ^ branchOnNotEqual);

    assign nextPc = takeBranch ? branchTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/instructionMemory.sv
`timescale 1ns/100ps
`default_nettype none

module instructionMemory import rvCorePkg::*; #(
    parameter int imemDepthLog2 = 8
) (
    input  logic            CLK,
    input  progWrite_t      prog,
    input  logic [xlen-1:0] pc,
    output instr_t          instr
);

    logic [31:0] mem [2**imemDepthLog2];

    initial begin
        // Unwritten words decode as no-ops
        for (int i = 0; i < 2**imemDepthLog2; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (prog.enable) begin
            mem[imemDepthLog2'(prog.wordAddr)] <= prog.data;
        end
    end

    assign instr = mem[pc[imemDepthLog2+1:2]]; // Byte address to word index

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile import rvCorePkg::*; (
    input  logic                    CLK,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] readAddrA,
    input  logic [regAddrWidth-1:0] readAddrB,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic                    writeEnable,
    input  logic [xlen-1:0]         writeData,
    output logic [xlen-1:0]         readDataA,
    output logic [xlen-1:0]         readDataB
);

    logic [xlen-1:0] regs [2**regAddrWidth];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // x0 reads as zero whatever was attempted
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

//--- rtl/immediateGen.sv
`timescale 1ns/100ps
`default_nettype none

module immediateGen import rvCorePkg::*; (
    input  instr_t          instr,
    output logic [xlen-1:0] imm
);

    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;

    assign immI = {{20{instr.iFields.imm11_0[11]}}, instr.iFields.imm11_0};

    assign immS = {{20{instr.sFields.immHi[6]}}, instr.sFields.immHi, instr.sFields.immLo};

    // Branch offset with the implicit zero LSB, so no separate shift
    assign immB = {{19{instr.bFields.imm12}}, instr.bFields.imm12, instr.bFields.imm11,
                   instr.bFields.imm10_5, instr.bFields.imm4_1, 1'b0};

    always_comb begin
        case (instr.rFields.opcode)
            opI, opLoad: imm = immI;
            opStore:     imm = immS;
            opBranch:    imm = immB;
            default:     imm = '0; // R-type and unknowns
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/controlDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module controlDecoder import rvCorePkg::*; (
    input  instr_t instr,
    input  logic   reset,
    output ctrl_t  ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr.rFields.opcode;
    assign funct3 = instr.rFields.funct3;
    assign funct7 = instr.rFields.funct7;

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        if (!reset) begin
            case (opcode)
                opR: begin
                    ctrl.regWrite = 1'b1;
                    case (funct3)
                        f3AddSub: ctrl.aluOp = funct7[5] ? aluSub : aluAdd;
                        f3Slt:    ctrl.aluOp = aluSlt;
                        f3Xor:    ctrl.aluOp = aluXor;
                        f3Or:     ctrl.aluOp = aluOr;
                        f3And:    ctrl.aluOp = aluAnd;
                        default:  ctrl.regWrite = 1'b0; // Shifts not supported
                    endcase
                end
                opI: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    // No funct7 here, bit 30 belongs to the immediate
                    case (funct3)
                        f3AddSub: ctrl.aluOp = aluAdd;
                        f3Or:     ctrl.aluOp = aluOr;
                        f3And:    ctrl.aluOp = aluAnd;
                        default:  ctrl.regWrite = 1'b0;
                    endcase
                end
                opLoad: begin
                    if (funct3 == f3Word) begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.aluSrcImm = 1'b1;
                        ctrl.memToReg  = 1'b1;
                    end
                end
                opStore: begin
                    if (funct3 == f3Word) begin
                        ctrl.aluSrcImm = 1'b1;
                        ctrl.memWrite  = 1'b1;
                    end
                end
                opBranch: begin
                    ctrl.aluOp            = aluSub; // Compare by subtracting
                    ctrl.branch           = (funct3 == f3Beq) || (funct3 == f3Bne);
                    ctrl.branchOnNotEqual = (funct3 == f3Bne);
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import rvCorePkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOp_t          op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {{(xlen-1){1'b0}}, lessThan};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // Equality test for branches

endmodule

`default_nettype wire

//--- rtl/dataMemory.sv
`timescale 1ns/100ps
`default_nettype none

module dataMemory import rvCorePkg::*; #(
    parameter int dmemDepthLog2 = 8
) (
    input  logic            CLK,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] writeData,
    input  logic            writeEnable,
    output logic [xlen-1:0] readData
);

    logic [xlen-1:0]          mem [2**dmemDepthLog2];
    logic [dmemDepthLog2-1:0] wordIndex;

    // Low two bits dropped, upper bits wrap
    assign wordIndex = addr[dmemDepthLog2+1:2];

    always_ff @(posedge CLK) begin
        if (writeEnable) begin
            mem[wordIndex] <= writeData;
        end
    end

    assign readData = mem[wordIndex];

endmodule

`default_nettype wire

//--- rtl/singleCycleCore.sv
`timescale 1ns/100ps
`default_nettype none

module singleCycleCore import rvCorePkg::*; #(
    parameter int imemDepthLog2 = 8,
    parameter int dmemDepthLog2 = 8
) (
    input  logic            CLK,
    input  logic            reset,
    input  progWrite_t      prog,
    output retire_t         retire,
    output logic [xlen-1:0] memData
);

    logic            running;   // Low for reset and the first edge after it
    logic            fetchHold;
    logic [xlen-1:0] pc;
    instr_t          instr;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluResult;
    logic            aluZero;
    logic [xlen-1:0] memReadData;
    logic [xlen-1:0] writeBack;
    logic            regWriteEn;
    logic            memWriteEn;

    always_ff @(posedge CLK) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign fetchHold  = reset | ~running; // PC stays at 0 until running
    assign regWriteEn = ctrl.regWrite & running;
    assign memWriteEn = ctrl.memWrite & running;

    fetchUnit fetch (
        .CLK(CLK), .reset(fetchHold), .branch(ctrl.branch),
        .branchOnNotEqual(ctrl.branchOnNotEqual), .zero(aluZero), .imm(imm), .pc(pc)
    );

    instructionMemory #(.imemDepthLog2(imemDepthLog2)) imem (
        .CLK(CLK), .prog(prog), .pc(pc), .instr(instr)
    );

    registerFile regs (
        .CLK(CLK), .reset(reset),
        .readAddrA(instr.rFields.rs1), .readAddrB(instr.rFields.rs2),
        .writeAddr(instr.rFields.rd), .writeEnable(regWriteEn), .writeData(writeBack),
        .readDataA(rs1Data), .readDataB(rs2Data)
    );

    immediateGen immGen (.instr(instr), .imm(imm));

    controlDecoder decoder (.instr(instr), .reset(reset), .ctrl(ctrl));

    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    alu aluUnit (.a(rs1Data), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(aluZero));

    dataMemory #(.dmemDepthLog2(dmemDepthLog2)) dmem (
        .CLK(CLK), .addr(aluResult), .writeData(rs2Data),
        .writeEnable(memWriteEn), .readData(memReadData)
    );

    assign writeBack = ctrl.memToReg ? memReadData : aluResult;

    // Describes the instruction executing this cycle
    assign retire.valid    = running;
    assign retire.pc       = pc;
    assign retire.regWrite = regWriteEn;
    assign retire.rd       = instr.rFields.rd;
    assign retire.regData  = writeBack;
    assign retire.memWrite = memWriteEn;
    assign retire.memAddr  = aluResult;

    assign memData = rs2Data; // Store data

endmodule

`default_nettype wire

//--- test/singleCycleCore_chk.sv
`timescale 1ns/100ps
`default_nettype none

module singleCycleCoreChk import rvCorePkg::*; (
    input logic            CLK,
    input logic            reset,
    input retire_t         retire,
    input logic [xlen-1:0] regZero
);

    // Valid clears on the first edge of reset
    validLowInReset: assert property (@(posedge CLK) reset |=> !retire.valid)
        else $error("retire.valid high while reset is held");

    regZeroFixed: assert property (@(posedge CLK)
        (retire.regWrite && retire.rd == '0) |=> (regZero == '0))
        else $error("register 0 changed by a write to rd 0");

    pcAligned: assert property (@(posedge CLK) !reset |-> (retire.pc[1:0] == 2'b00))
        else $error("pc is not word aligned");

    writesExclusive: assert property (@(posedge CLK) !(retire.memWrite && retire.regWrite))
        else $error("memWrite and regWrite set together");

endmodule

bind singleCycleCore singleCycleCoreChk chk (
    .CLK(CLK), .reset(reset), .retire(retire), .regZero(regs.regs[0])
);

`default_nettype wire

//--- test/singleCycleCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module singleCycleCoreTb import rvCorePkg::*; ();

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 10;
    localparam int maxSteps    = 64;
    localparam int maxProgLen  = 32;
    localparam int numTests    = 5;
    localparam int watchdogNs  = numTests * (maxProgLen + resetCycles + maxSteps + 20) * clkPeriod;

    logic            CLK;
    logic            reset;
    progWrite_t      prog;
    retire_t         retire;
    logic [xlen-1:0] memData;

    // Reference model state
    logic [31:0] progWords [$];
    logic [31:0] skipPcs [$];   // Addresses a taken branch jumps over
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [256];
    logic [31:0] modelPc;
    logic [31:0] lcgState;

    logic        expRegWrite;
    logic        expMemWrite;
    logic [4:0]  expRd;
    logic [31:0] expPc;
    logic [31:0] expRegData;
    logic [31:0] expMemAddr;
    logic [31:0] expMemData;

    int errorCount;
    int checkCount;
    int testCount;

    singleCycleCore #(.imemDepthLog2(8), .dmemDepthLog2(8)) dut (
        .CLK(CLK), .reset(reset), .prog(prog), .retire(retire), .memData(memData)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    function logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function logic [11:0] randImm();
        logic [31:0] r;
        r = lcgNext();
        return r[27:16]; // Upper bits are the better ones
    endfunction

    function logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opR};
    endfunction

    function logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opStore};
    endfunction

    function logic [31:0] encodeB(input logic [12:0] off, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("[FAIL] %0d ns %s: expected %h, got %h", $time, what, exp, got);
            errorCount++;
        end
    endtask

    // Works out the expected retire fields, then advances the model
    task automatic modelStep();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] addr;
        logic [31:0] result;
        logic [31:0] nextPc;
        int          idx;
        idx         = int'(modelPc >> 2);
        ins         = (idx < progWords.size()) ? progWords[idx] : 32'h0;
        immI        = {{20{ins[31]}}, ins[31:20]};
        immS        = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB        = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        a           = modelRegs[ins[19:15]];
        b           = modelRegs[ins[24:20]];
        result      = 32'h0;
        nextPc      = modelPc + 32'd4;
        expPc       = modelPc;
        expRd       = ins[11:7];
        expRegWrite = 1'b0;
        expMemWrite = 1'b0;
        expMemAddr  = 32'h0;
        expMemData  = b;
        case (ins[6:0])
            opR: begin
                expRegWrite = 1'b1;
                case (ins[14:12])
                    f3AddSub: result = ins[30] ? a - b : a + b;
                    f3Slt:    result = 32'($signed(a) < $signed(b));
                    f3Xor:    result = a ^ b;
                    f3Or:     result = a | b;
                    f3And:    result = a & b;
                    default:  expRegWrite = 1'b0;
                endcase
            end
            opI: begin
                expRegWrite = 1'b1;
                case (ins[14:12])
                    f3AddSub: result = a + immI;
                    f3Or:     result = a | immI;
                    f3And:    result = a & immI;
                    default:  expRegWrite = 1'b0;
                endcase
            end
            opLoad: if (ins[14:12] == f3Word) begin
                addr        = a + immI;
                result      = modelMem[addr[9:2]];
                expRegWrite = 1'b1;
            end
            opStore: if (ins[14:12] == f3Word) begin
                addr               = a + immS;
                modelMem[addr[9:2]] = b;
                expMemWrite        = 1'b1;
                expMemAddr         = addr;
            end
            opBranch: begin
                if ((ins[14:12] == f3Beq && a == b) || (ins[14:12] == f3Bne && a != b)) begin
                    nextPc = modelPc + immB;
                end
            end
            default: ; // Unknown opcodes change nothing
        endcase
        expRegData = result;
        if (expRegWrite && expRd != 5'd0) begin
            modelRegs[expRd] = result;
        end
        modelPc = nextPc;
    endtask

    task automatic checkRetire();
        checkValue("retire.valid", 32'(retire.valid), 32'd1);
        checkValue("retire.pc", retire.pc, expPc);
        checkValue("retire.regWrite", 32'(retire.regWrite), 32'(expRegWrite));
        checkValue("retire.memWrite", 32'(retire.memWrite), 32'(expMemWrite));
        if (expRegWrite) begin
            checkValue("retire.rd", 32'(retire.rd), 32'(expRd));
            checkValue("retire.regData", retire.regData, expRegData);
        end
        if (expMemWrite) begin
            checkValue("retire.memAddr", retire.memAddr, expMemAddr);
            checkValue("memData", memData, expMemData);
        end
        foreach (skipPcs[i]) begin
            assert (retire.pc != skipPcs[i]) else begin
                $display("Skipped instruction at pc %h retired at %0d ns", skipPcs[i], $time);
                errorCount++;
            end
        end
    endtask

    // Loads progWords under reset, then runs it against the model
    task automatic loadAndRun(input string name);
        int steps;
        int errorsBefore;
        errorsBefore = errorCount;
        reset        = 1'b1;
        foreach (progWords[i]) begin
            prog.enable   = 1'b1;
            prog.wordAddr = 8'(i);
            prog.data     = progWords[i];
            @(negedge CLK);
        end
        prog = '0;
        repeat (resetCycles) begin
            @(negedge CLK);
            checkValue("retire.valid in reset", 32'(retire.valid), 32'd0);
            checkValue("retire.pc in reset", retire.pc, 32'd0);
            checkValue("retire.regWrite in reset", 32'(retire.regWrite), 32'd0);
            checkValue("retire.memWrite in reset", 32'(retire.memWrite), 32'd0);
        end
        foreach (modelRegs[i]) modelRegs[i] = 32'h0;
        modelPc = 32'h0;
        reset   = 1'b0;
        @(negedge CLK); // First edge after release holds pc at 0
        steps = 0;
        while (modelPc != 32'(progWords.size() * 4) && steps < maxSteps) begin
            modelStep();
            checkRetire();
            steps++;
            @(negedge CLK);
        end
        assert (steps < maxSteps) else begin
            $display("Test %s did not reach the end of its program", name);
            errorCount++;
        end
        testCount++;
        $display("%s: %0d retired, %0d errors", name, steps, errorCount - errorsBefore);
        progWords.delete();
        skipPcs.delete();
    endtask

    task automatic arithTest();
        progWords.push_back(encodeI(randImm(), 0, f3AddSub, 1, opI));
        progWords.push_back(encodeI(randImm() | 12'h800, 0, f3AddSub, 2, opI)); // Negative
        progWords.push_back(encodeI(randImm() | 12'h800, 0, f3AddSub, 3, opI));
        progWords.push_back(encodeI(randImm() & 12'h7ff, 0, f3AddSub, 4, opI)); // Positive
        progWords.push_back(encodeR(f7Base, 2, 1, f3AddSub, 5));
        progWords.push_back(encodeR(f7Sub, 2, 1, f3AddSub, 6));
        progWords.push_back(encodeR(f7Base, 2, 1, f3And, 7));
        progWords.push_back(encodeR(f7Base, 2, 1, f3Or, 8));
        progWords.push_back(encodeR(f7Base, 2, 1, f3Xor, 9));
        progWords.push_back(encodeR(f7Base, 4, 2, f3Slt, 10));
        progWords.push_back(encodeR(f7Base, 2, 4, f3Slt, 11));
        progWords.push_back(encodeR(f7Base, 3, 2, f3Slt, 12)); // Both negative
        progWords.push_back(encodeI(randImm(), 1, f3And, 13, opI));
        progWords.push_back(encodeI(randImm(), 2, f3Or, 14, opI));
        progWords.push_back(encodeI(randImm(), 5, f3AddSub, 15, opI));
        loadAndRun("arithmetic");
    endtask

    task automatic regZeroTest();
        progWords.push_back(encodeI(77, 0, f3AddSub, 1, opI));
        progWords.push_back(encodeI(55, 0, f3AddSub, 0, opI));
        progWords.push_back(encodeR(f7Base, 1, 1, f3AddSub, 0));
        progWords.push_back(encodeR(f7Base, 0, 0, f3AddSub, 2));
        progWords.push_back(encodeR(f7Base, 1, 0, f3AddSub, 3));
        progWords.push_back(encodeR(f7Sub, 0, 1, f3AddSub, 4));
        loadAndRun("register zero");
    endtask

    task automatic loadStoreTest();
        progWords.push_back(encodeI(16, 0, f3AddSub, 1, opI));
        progWords.push_back(encodeI(randImm(), 0, f3AddSub, 2, opI));
        progWords.push_back(encodeI(randImm() | 12'h800, 0, f3AddSub, 3, opI));
        progWords.push_back(encodeS(0, 2, 1));
        progWords.push_back(encodeS(4, 3, 1));
        progWords.push_back(encodeS(-12'd8, 3, 1));
        progWords.push_back(encodeS(200, 1, 0));
        progWords.push_back(encodeI(0, 1, f3Word, 4, opLoad));
        progWords.push_back(encodeI(4, 1, f3Word, 5, opLoad));
        progWords.push_back(encodeI(8, 0, f3Word, 6, opLoad));
        progWords.push_back(encodeR(f7Base, 5, 4, f3AddSub, 7));
        progWords.push_back(encodeI(200, 0, f3Word, 8, opLoad));
        progWords.push_back(encodeI(0, 8, f3Word, 9, opLoad)); // Address from a load
        progWords.push_back(encodeR(f7Base, 6, 9, f3AddSub, 10));
        loadAndRun("load store");
    endtask

    task automatic branchTest();
        progWords.push_back(encodeI(5, 0, f3AddSub, 1, opI));
        progWords.push_back(encodeI(5, 0, f3AddSub, 2, opI));
        progWords.push_back(encodeI(7, 0, f3AddSub, 3, opI));
        progWords.push_back(encodeI(1, 0, f3AddSub, 7, opI));
        progWords.push_back(encodeB(12, 2, 1, f3Beq));       // Taken forward
        progWords.push_back(encodeI(1, 0, f3AddSub, 10, opI));
        progWords.push_back(encodeI(2, 0, f3AddSub, 10, opI));
        progWords.push_back(encodeB(12, 3, 1, f3Bne));       // Taken forward
        progWords.push_back(encodeI(1, 0, f3AddSub, 11, opI));
        progWords.push_back(encodeI(2, 0, f3AddSub, 11, opI));
        progWords.push_back(encodeI(1, 4, f3AddSub, 4, opI));
        progWords.push_back(encodeB(-13'd4, 1, 4, f3Bne));   // Loop until x4 is 5
        progWords.push_back(encodeB(8, 3, 1, f3Beq));        // Not taken
        progWords.push_back(encodeB(8, 2, 1, f3Bne));        // Not taken
        progWords.push_back(encodeI(2, 5, f3AddSub, 5, opI));
        progWords.push_back(encodeR(f7Base, 3, 5, f3Slt, 6));
        progWords.push_back(encodeB(-13'd8, 7, 6, f3Beq));   // Loop while x5 below 7
        progWords.push_back(encodeB(8, 2, 4, f3Beq));
        progWords.push_back(encodeI(9, 0, f3AddSub, 12, opI));
        progWords.push_back(encodeI(3, 0, f3AddSub, 13, opI));
        skipPcs = '{32'd20, 32'd24, 32'd32, 32'd36, 32'd72};
        loadAndRun("branches");
    endtask

    task automatic resetTest();
        for (int r = 1; r < 32; r++) begin
            progWords.push_back(encodeR(f7Base, 5'(r), 5'(r), f3Or, 5'(r)));
        end
        loadAndRun("reset");
    endtask

    initial begin
        reset      = 1'b1;
        prog       = '0;
        lcgState   = 32'd64;
        errorCount = 0;
        checkCount = 0;
        testCount  = 0;
        @(negedge CLK);
        arithTest();
        regZeroTest();
        loadStoreTest();
        branchTest();
        resetTest(); // Runs last so earlier tests leave registers dirty
        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- singleCycleCore.f
rtl/rvCorePkg.sv
rtl/fetchUnit.sv
rtl/instructionMemory.sv
rtl/registerFile.sv
rtl/immediateGen.sv
rtl/controlDecoder.sv
rtl/alu.sv
rtl/dataMemory.sv
rtl/singleCycleCore.sv
test/singleCycleCore_chk.sv
test/singleCycleCoreTb.sv

//--- Makefile
# Verilator build and run for the single-cycle core

VERILATOR ?= verilator
TOP       ?= singleCycleCoreTb
FILELIST  ?= singleCycleCore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_TEXT ?= NO ERRORS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Fails unless the pass message appears on a line of its own
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
